// ==== src/minerPkg.sv ====
`default_nettype none

package minerPkg;

	localparam int HEADER_BITS = 640;
	localparam int HASH_BITS = 256;
	localparam int NONCE_BITS = 32;

	// index 0 is the constant for round 0
	localparam logic [0:63][31:0] ROUND_K = {
		256'h428a2f98_71374491_b5c0fbcf_e9b5dba5_3956c25b_59f111f1_923f82a4_ab1c5ed5,
		256'hd807aa98_12835b01_243185be_550c7dc3_72be5d74_80deb1fe_9bdc06a7_c19bf174,
		256'he49b69c1_efbe4786_0fc19dc6_240ca1cc_2de92c6f_4a7484aa_5cb0a9dc_76f988da,
		256'h983e5152_a831c66d_b00327c8_bf597fc7_c6e00bf3_d5a79147_06ca6351_14292967,
		256'h27b70a85_2e1b2138_4d2c6dfc_53380d13_650a7354_766a0abb_81c2c92e_92722c85,
		256'ha2bfe8a1_a81a664b_c24b8b70_c76c51a3_d192e819_d6990624_f40e3585_106aa070,
		256'h19a4c116_1e376c08_2748774c_34b0bcb5_391c0cb3_4ed8aa4a_5b9cca4f_682e6ff3,
		256'h748f82ee_78a5636f_84c87814_8cc70208_90befffa_a4506ceb_bef9a3f7_c67178f2
	};

	// H0 sits in the top word
	localparam logic [HASH_BITS-1:0] HASH_IV = {
		32'h6a09e667,
		32'hbb67ae85,
		32'h3c6ef372,
		32'ha54ff53a,
		32'h510e527f,
		32'h9b05688c,
		32'h1f83d9ab,
		32'h5be0cd19
	};

	typedef struct packed {
		logic [NONCE_BITS-1:0] nonce;
		logic [HASH_BITS-1:0] hash;
		logic hit;
	} minerResult_t;

endpackage

`default_nettype wire

// ==== src/sha256Compress.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha256Compress (
	input  logic clock,
	input  logic rst,
	input  logic go,
	input  logic [511:0] block,
	input  logic [minerPkg::HASH_BITS-1:0] chainIn,
	output logic [minerPkg::HASH_BITS-1:0] digest,
	output logic ready
);
	import minerPkg::*;

	// working variables a..h, a at index 0
	logic [0:7][31:0] v;
	// message window, w[0] is the word for the current round
	logic [0:15][31:0] w;
	logic [HASH_BITS-1:0] chain;
	logic [6:0] round;
	logic running;
	logic [31:0] sum1, sum0, ch, maj, t1, t2;
	logic [31:0] ws0, ws1, wNext;

	function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	always_comb begin
		sum1 = rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25);
		ch = (v[4] & v[5]) ^ (~v[4] & v[6]);
		t1 = v[7] + sum1 + ch + ROUND_K[round[5:0]] + w[0];
		sum0 = rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22);
		maj = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
		t2 = sum0 + maj;
		// schedule word sixteen rounds ahead
		ws0 = rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3);
		ws1 = rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10);
		wNext = ws1 + w[9] + ws0 + w[0];
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			running <= 1'b0;
			round <= '0;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			if (go) begin
				running <= 1'b1;
				round <= '0;
			end else if (running) begin
				round <= round + 7'd1;
				// round 64 is the feed-forward step
				if (round == 7'd64) begin
					running <= 1'b0;
					ready <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (go) begin
			v <= chainIn;
			chain <= chainIn;
			w <= block;
		end else if (running) begin
			if (round < 7'd64) begin
				v <= {t1 + t2, v[0:2], v[3] + t1, v[4:6]};
				w <= {w[1:15], wNext};
			end else begin
				for (int i = 0; i < 8; i++) begin
					digest[HASH_BITS-1-32*i -: 32] <= chain[HASH_BITS-1-32*i -: 32] + v[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/minerControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module minerControl (
	input  logic clock,
	input  logic rst,
	input  logic [minerPkg::HEADER_BITS-1:0] blockHeader,
	input  logic [7:0] zeroBits,
	input  logic jobValid,
	input  logic [minerPkg::NONCE_BITS-1:0] jobNonce,
	output logic jobReady,
	output logic resValid,
	output minerPkg::minerResult_t resData,
	input  logic resReady
);
	import minerPkg::*;

	typedef enum logic [2:0] {IDLE, BLK1, BLK2, FINAL, HOLD} phase_t;

	phase_t phase;
	logic [NONCE_BITS-1:0] nonceReg;
	logic go, shaReady, hit;
	logic [511:0] block;
	logic [HASH_BITS-1:0] chainIn, digest, leHash;
	logic [8:0] shiftAmt;

	assign jobReady = (phase == IDLE);

	// next block starts in the same cycle the previous digest appears
	assign go = (jobValid && jobReady) || (shaReady && (phase == BLK1 || phase == BLK2));

	always_comb begin
		case (phase)
			BLK1: block = {blockHeader[127:32], nonceReg, 1'b1, 319'b0, 64'(HEADER_BITS)};
			BLK2: block = {digest, 1'b1, 191'b0, 64'(HASH_BITS)};
			default: block = blockHeader[HEADER_BITS-1:128];
		endcase
	end

	// block two chains from the block one digest, the rest start from the IV
	assign chainIn = (phase == BLK1) ? digest : HASH_IV;

	sha256Compress sha (
		.clock(clock),
		.rst(rst),
		.go(go),
		.block(block),
		.chainIn(chainIn),
		.digest(digest),
		.ready(shaReady)
	);

	// target test on the byte reversed digest
	assign leHash = {<<8{digest}};
	assign shiftAmt = 9'd256 - {1'b0, zeroBits};
	assign hit = ((leHash >> shiftAmt) == '0);

	assign resValid = (phase == HOLD) || (phase == FINAL && shaReady);
	assign resData = '{nonce: nonceReg, hash: digest, hit: hit};

	always_ff @(posedge clock) begin
		if (rst) begin
			phase <= IDLE;
		end else begin
			case (phase)
				IDLE: if (jobValid) phase <= BLK1;
				BLK1: if (shaReady) phase <= BLK2;
				BLK2: if (shaReady) phase <= FINAL;
				FINAL: if (shaReady) phase <= resReady ? IDLE : HOLD;
				HOLD: if (resReady) phase <= IDLE;
				default: phase <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (jobValid && jobReady) begin
			nonceReg <= jobNonce;
		end
	end

endmodule

`default_nettype wire

// ==== src/nonceDispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module nonceDispatch #(
	parameter int NUM_CORES = 4
) (
	input  logic clock,
	input  logic rst,
	input  logic start,
	input  logic [minerPkg::NONCE_BITS-1:0] nonceFirst,
	input  logic [minerPkg::NONCE_BITS-1:0] nonceLast,
	input  logic stopSearch,
	input  logic [NUM_CORES-1:0] jobReady,
	output logic [NUM_CORES-1:0] jobValid,
	output logic [minerPkg::NONCE_BITS-1:0] jobNonce,
	output logic rangeDone
);

	logic active;
	logic issue;
	logic [NUM_CORES-1:0] lowestReady;

	// isolate the lowest set bit
	assign lowestReady = jobReady & (~jobReady + 1'b1);
	assign jobValid = (active && !stopSearch) ? lowestReady : '0;
	assign issue = |jobValid;

	always_ff @(posedge clock) begin
		if (rst) begin
			active <= 1'b0;
			rangeDone <= 1'b0;
		end else if (start) begin
			active <= 1'b1;
			rangeDone <= 1'b0;
		end else if (active && stopSearch) begin
			active <= 1'b0;
			rangeDone <= 1'b1;
		end else if (issue && jobNonce == nonceLast) begin
			active <= 1'b0;
			rangeDone <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			jobNonce <= nonceFirst;
		end else if (issue) begin
			jobNonce <= jobNonce + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/resultArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module resultArbiter #(
	parameter int NUM_CORES = 4
) (
	input  logic clock,
	input  logic rst,
	input  logic start,
	input  logic [NUM_CORES-1:0] resValid,
	input  minerPkg::minerResult_t resData [NUM_CORES],
	output logic [NUM_CORES-1:0] resReady,
	input  logic rangeDone,
	input  logic [NUM_CORES-1:0] jobReady,
	output logic stopSearch,
	output logic busy,
	output logic done,
	output logic found,
	output logic [minerPkg::NONCE_BITS-1:0] foundNonce,
	output logic [minerPkg::HASH_BITS-1:0] foundHash
);
	import minerPkg::*;

	localparam int PTR_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

	logic [PTR_W-1:0] rrPtr, grantIdx;
	logic take, better, allClear;
	minerResult_t taken;

	// first waiting core at or after the rotating pointer
	always_comb begin
		int idx;
		take = 1'b0;
		grantIdx = rrPtr;
		resReady = '0;
		for (int k = 0; k < NUM_CORES; k++) begin
			idx = (int'(rrPtr) + k) % NUM_CORES;
			if (!take && resValid[idx]) begin
				take = 1'b1;
				grantIdx = PTR_W'(idx);
				resReady[idx] = 1'b1;
			end
		end
	end

	assign taken = resData[grantIdx];
	// stopSearch doubles as the hit-seen flag
	assign better = take && taken.hit && (!stopSearch || taken.nonce < foundNonce);
	assign allClear = rangeDone && (&jobReady) && !(|resValid);

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			found <= 1'b0;
			stopSearch <= 1'b0;
			rrPtr <= '0;
		end else begin
			done <= 1'b0;
			if (take) begin
				rrPtr <= (int'(grantIdx) == NUM_CORES - 1) ? '0 : grantIdx + 1'b1;
			end
			if (start) begin
				busy <= 1'b1;
				found <= 1'b0;
				stopSearch <= 1'b0;
			end else begin
				if (better) begin
					stopSearch <= 1'b1;
				end
				if (busy && allClear) begin
					busy <= 1'b0;
					done <= 1'b1;
					found <= stopSearch;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (better) begin
			foundNonce <= taken.nonce;
			foundHash <= taken.hash;
		end
	end

endmodule

`default_nettype wire

// ==== src/minerTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module minerTop #(
	parameter int NUM_CORES = 4
) (
	input  logic clock,
	input  logic rst,
	input  logic start,
	input  logic [minerPkg::HEADER_BITS-1:0] blockHeader,
	input  logic [minerPkg::NONCE_BITS-1:0] nonceFirst,
	input  logic [minerPkg::NONCE_BITS-1:0] nonceLast,
	input  logic [7:0] zeroBits,
	output logic busy,
	output logic done,
	output logic found,
	output logic [minerPkg::NONCE_BITS-1:0] foundNonce,
	output logic [minerPkg::HASH_BITS-1:0] foundHash
);
	import minerPkg::*;

	logic [NUM_CORES-1:0] jobValid, jobReady, resValid, resReady;
	logic [NONCE_BITS-1:0] jobNonce;
	logic rangeDone, stopSearch;
	minerResult_t resData [NUM_CORES];

	nonceDispatch #(.NUM_CORES(NUM_CORES)) dispatch (
		.clock(clock),
		.rst(rst),
		.start(start),
		.nonceFirst(nonceFirst),
		.nonceLast(nonceLast),
		.stopSearch(stopSearch),
		.jobReady(jobReady),
		.jobValid(jobValid),
		.jobNonce(jobNonce),
		.rangeDone(rangeDone)
	);

	// header and target are shared by all cores
	for (genvar i = 0; i < NUM_CORES; i++) begin : gCore
		minerControl core (
			.clock(clock),
			.rst(rst),
			.blockHeader(blockHeader),
			.zeroBits(zeroBits),
			.jobValid(jobValid[i]),
			.jobNonce(jobNonce),
			.jobReady(jobReady[i]),
			.resValid(resValid[i]),
			.resData(resData[i]),
			.resReady(resReady[i])
		);
	end

	resultArbiter #(.NUM_CORES(NUM_CORES)) arbiter (
		.clock(clock),
		.rst(rst),
		.start(start),
		.resValid(resValid),
		.resData(resData),
		.resReady(resReady),
		.rangeDone(rangeDone),
		.jobReady(jobReady),
		.stopSearch(stopSearch),
		.busy(busy),
		.done(done),
		.found(found),
		.foundNonce(foundNonce),
		.foundHash(foundHash)
	);

endmodule

`default_nettype wire

// ==== tb/minerTop_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module minerTopAssertions #(
	parameter int NUM_CORES = 4
) (
	input logic clock,
	input logic rst,
	input logic start,
	input logic done,
	input logic found,
	input logic [NUM_CORES-1:0] jobValid,
	input logic [NUM_CORES-1:0] resValid,
	input logic [NUM_CORES-1:0] resReady,
	input minerPkg::minerResult_t resData [NUM_CORES]
);

	logic doneSeen;

	// cleared on start, set by the done pulse
	always_ff @(posedge clock) begin
		if (rst || start) begin
			doneSeen <= 1'b0;
		end else if (done) begin
			doneSeen <= 1'b1;
		end
	end

	// dispatcher offers a nonce to one core at a time
	oneJob: assert property (@(posedge clock) disable iff (rst) $onehot0(jobValid))
		else $error("jobValid has more than one bit set");

	for (genvar i = 0; i < NUM_CORES; i++) begin : gHold
		holdResult: assert property (@(posedge clock) disable iff (rst)
			resValid[i] && !resReady[i] |=> resValid[i] && $stable(resData[i]))
			else $error("core %0d changed or dropped its result while it waited", i);
	end

	donePulse: assert property (@(posedge clock) disable iff (rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// found rises together with done
	foundAfterDone: assert property (@(posedge clock) disable iff (rst)
		found |-> (done || doneSeen))
		else $error("found is high but no done has been seen since start");

endmodule

bind minerTop minerTopAssertions #(.NUM_CORES(NUM_CORES)) checks (
	.clock(clock),
	.rst(rst),
	.start(start),
	.done(done),
	.found(found),
	.jobValid(jobValid),
	.resValid(resValid),
	.resReady(resReady),
	.resData(resData)
);

`default_nettype wire

// ==== tb/minerTop_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module minerTop_tb;
	import minerPkg::*;

	typedef struct packed {
		logic [31:0] seed;
		logic [31:0] nonceFirst;
		logic [31:0] nonceLast;
		logic [7:0] zeroBits;
		logic expFound;
		logic abort;
	} stimRow_t;

	localparam int NUM_ROWS = 6;
	// header seed, first nonce, last nonce, zero bits, expected found, reset mid-search
	localparam stimRow_t ROWS [NUM_ROWS] = '{
		'{32'd1, 32'd100, 32'd107, 8'd0, 1'b1, 1'b0},
		'{32'd2, 32'd1000, 32'd1063, 8'd4, 1'b1, 1'b0},
		'{32'd3, 32'd500, 32'd511, 8'd40, 1'b0, 1'b0},
		'{32'd4, 32'd7000, 32'd7015, 8'd1, 1'b1, 1'b0},
		'{32'd5, 32'd42, 32'd43, 8'd0, 1'b1, 1'b0},
		'{32'd6, 32'd200, 32'd215, 8'd1, 1'b1, 1'b1}
	};

	logic clock, rst, start;
	logic [HEADER_BITS-1:0] blockHeader;
	logic [NONCE_BITS-1:0] nonceFirst, nonceLast, foundNonce;
	logic [7:0] zeroBits;
	logic busy, done, found;
	logic [HASH_BITS-1:0] foundHash;
	int errors, rowErrors, failedRows;

	minerTop #(.NUM_CORES(4)) DUT (
		.clock(clock),
		.rst(rst),
		.start(start),
		.blockHeader(blockHeader),
		.nonceFirst(nonceFirst),
		.nonceLast(nonceLast),
		.zeroBits(zeroBits),
		.busy(busy),
		.done(done),
		.found(found),
		.foundNonce(foundNonce),
		.foundHash(foundHash)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [HEADER_BITS-1:0] makeHeader(input logic [31:0] seed);
		logic [31:0] state;
		logic [HEADER_BITS-1:0] hdr;
		state = 32'd83414 + seed;
		for (int i = 0; i < 20; i++) begin
			state = xorshift32(state);
			hdr[HEADER_BITS-1-32*i -: 32] = state;
		end
		return hdr;
	endfunction

	function automatic logic [31:0] rotateRight(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// textbook compression with the full 64-word schedule
	function automatic logic [255:0] compress(input logic [511:0] blk, input logic [255:0] chain);
		logic [31:0] w [64];
		logic [31:0] a, b, c, d, e, f, g, h, s0, s1, t1, t2;
		logic [255:0] res;
		for (int t = 0; t < 16; t++) begin
			w[t] = blk[511-32*t -: 32];
		end
		for (int t = 16; t < 64; t++) begin
			s0 = rotateRight(w[t-15], 7) ^ rotateRight(w[t-15], 18) ^ (w[t-15] >> 3);
			s1 = rotateRight(w[t-2], 17) ^ rotateRight(w[t-2], 19) ^ (w[t-2] >> 10);
			w[t] = w[t-16] + s0 + w[t-7] + s1;
		end
		{a, b, c, d, e, f, g, h} = chain;
		for (int t = 0; t < 64; t++) begin
			s1 = rotateRight(e, 6) ^ rotateRight(e, 11) ^ rotateRight(e, 25);
			t1 = h + s1 + ((e & f) ^ (~e & g)) + ROUND_K[t] + w[t];
			s0 = rotateRight(a, 2) ^ rotateRight(a, 13) ^ rotateRight(a, 22);
			t2 = s0 + ((a & b) ^ (a & c) ^ (b & c));
			{a, b, c, d, e, f, g, h} = {t1 + t2, a, b, c, d + t1, e, f, g};
		end
		res = {a, b, c, d, e, f, g, h};
		for (int i = 0; i < 8; i++) begin
			res[255-32*i -: 32] = res[255-32*i -: 32] + chain[255-32*i -: 32];
		end
		return res;
	endfunction

	// nonce replaces the last four header bytes
	function automatic logic [255:0] hashNonce(input logic [HEADER_BITS-1:0] hdr,
			input logic [31:0] nonce);
		logic [255:0] h1, h2;
		h1 = compress(hdr[639:128], HASH_IV);
		h2 = compress({hdr[127:32], nonce, 1'b1, 319'b0, 64'd640}, h1);
		return compress({h2, 1'b1, 191'b0, 64'd256}, HASH_IV);
	endfunction

	function automatic logic meetsTarget(input logic [255:0] hash, input logic [7:0] zb);
		logic [255:0] le;
		for (int i = 0; i < 32; i++) begin
			le[8*i +: 8] = hash[255-8*i -: 8];
		end
		for (int i = 0; i < int'(zb); i++) begin
			if (le[255-i]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// scan in rising order, so the first hit is the smallest nonce
	task automatic searchModel(input logic [HEADER_BITS-1:0] hdr, input stimRow_t row,
			output logic hit, output logic [31:0] nonce, output logic [255:0] hash);
		logic [255:0] h;
		hit = 1'b0;
		nonce = '0;
		hash = '0;
		for (longint n = row.nonceFirst; n <= row.nonceLast; n++) begin
			h = hashNonce(hdr, n[31:0]);
			if (meetsTarget(h, row.zeroBits)) begin
				hit = 1'b1;
				nonce = n[31:0];
				hash = h;
				break;
			end
		end
	endtask

	task automatic reportMismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		rowErrors++;
	endtask

	task automatic startSearch(input stimRow_t row, input logic [HEADER_BITS-1:0] hdr);
		@(posedge clock);
		#1;
		blockHeader = hdr;
		nonceFirst = row.nonceFirst;
		nonceLast = row.nonceLast;
		zeroBits = row.zeroBits;
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
	endtask

	task automatic runRow(input int r);
		stimRow_t row;
		logic [HEADER_BITS-1:0] hdr;
		logic expHit;
		logic [31:0] expNonce;
		logic [255:0] expHash;
		row = ROWS[r];
		hdr = makeHeader(row.seed);
		searchModel(hdr, row, expHit, expNonce, expHash);
		rowErrors = 0;
		if (expHit != row.expFound) begin
			$display("row %0d: the reference model does not agree with the table's found flag", r);
			rowErrors++;
		end
		if (row.abort) begin
			startSearch(row, hdr);
			repeat (40) @(posedge clock);
			#1;
			if (busy !== 1'b1) begin
				reportMismatch("busy was not high before the reset");
			end
			rst = 1'b1;
			repeat (3) @(posedge clock);
			#1;
			rst = 1'b0;
			if (busy !== 1'b0) begin
				reportMismatch("busy stayed high after reset in the middle of a search");
			end
		end
		startSearch(row, hdr);
		if (busy !== 1'b1) begin
			reportMismatch("busy did not rise after start");
		end
		if (found !== 1'b0) begin
			reportMismatch("found was not cleared by start");
		end
		do begin
			@(posedge clock);
			#1;
		end while (!done);
		if (found !== expHit) begin
			reportMismatch($sformatf("found is %0b, expected %0b", found, expHit));
		end
		if (expHit && foundNonce !== expNonce) begin
			reportMismatch($sformatf("foundNonce is %0d, expected %0d", foundNonce, expNonce));
		end
		if (expHit && foundHash !== expHash) begin
			reportMismatch($sformatf("foundHash is %h, expected %h", foundHash, expHash));
		end
		if (busy !== 1'b0) begin
			reportMismatch("busy still high after done");
		end
		errors += rowErrors;
		if (rowErrors != 0) begin
			failedRows++;
		end
		$display("row %0d: nonces %0d to %0d, zeroBits %0d, found %0b: %s", r, row.nonceFirst,
			row.nonceLast, row.zeroBits, found, (rowErrors == 0) ? "ok" : "FAILED");
	endtask

	// range length times 200 cycles plus 500 per row
	initial begin
		longint limit;
		limit = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += (longint'(ROWS[r].nonceLast) - longint'(ROWS[r].nonceFirst) + 1) * 200 + 500;
		end
		repeat (limit) @(posedge clock);
		$display("watchdog expired: the searches did not finish within %0d cycles", limit);
		$display("Test failures found");
		$finish;
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		blockHeader = '0;
		nonceFirst = '0;
		nonceLast = '0;
		zeroBits = '0;
		errors = 0;
		failedRows = 0;
		rowErrors = 0;
		// known SHA-256 vector for "abc" guards the model and its constants
		if (compress({32'h61626380, 448'b0, 32'h18}, HASH_IV) !==
				256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad) begin
			reportMismatch("reference SHA-256 model gives a wrong digest for abc");
		end
		errors += rowErrors;
		repeat (10) @(posedge clock);
		#1;
		rst = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			runRow(r);
		end
		$display("%0d rows run, %0d rows failed, %0d errors", NUM_ROWS, failedRows, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
src/minerPkg.sv
src/sha256Compress.sv
src/minerControl.sv
src/nonceDispatch.sv
src/resultArbiter.sv
src/minerTop.sv
tb/minerTop_assertions.sv
tb/minerTop_tb.sv

// ==== Makefile ====
TOP = minerTop_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

# the run passes only when the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
